/* include/i2c_consts.svh */
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// i2c_clk cycles per quarter of an SCL bit
`define I2C_QUARTER_DIV 5

// Receive FIFO entries, not counting the output register
`define I2C_FIFO_DEPTH 4

// Longest read in bytes
`define I2C_MAX_READ_LEN 4

// Width of the read length field
`define I2C_LEN_W 3

`endif

/* src/i2c_bus_pkg.sv */
package i2c_bus_pkg;

    // Quarters of one SCL bit, in bus order
    typedef enum logic [1:0] {
        Q_LOW_A,
        Q_RISE,
        Q_HIGH,
        Q_LOW_B
    } bus_phase_e;

    typedef enum logic [3:0] {
        IDLE,
        START,
        ADDR,
        ADDR_ACK,
        WR_DATA,
        WR_ACK,
        RD_WAIT,
        RD_DATA,
        RD_ACK,
        STOP,
        HOLD
    } ctrl_state_e;

endpackage

/* src/i2c_cmd_pkg.sv */
`include "i2c_consts.svh"

package i2c_cmd_pkg;

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } cmd_op_e;

    // One command as held by the controller
    typedef struct packed {
        cmd_op_e                 op;
        logic [6:0]              addr;
        // Only used by writes
        logic [7:0]              data;
        // Only used by reads
        logic [`I2C_LEN_W-1:0]   len;
        // End in HOLD instead of STOP
        logic                    rstart;
    } i2c_cmd_t;

endpackage

/* src/i2c_timing_if.sv */
interface i2c_timing_if
    import i2c_bus_pkg::*;
();

    // Bit clock enable from the controller
    logic       run;
    // Pulse on the first cycle of every quarter
    logic       tick;
    bus_phase_e phase;
    // SCL pull request for the current quarter
    logic       scl_low;

    modport gen (
        input  run,
        output tick,
        output phase,
        output scl_low
    );

    modport ctrl (
        output run,
        input  tick,
        input  phase,
        input  scl_low
    );

endinterface

/* src/i2c_scl_gen.sv */
`include "i2c_consts.svh"

module i2c_scl_gen
    import i2c_bus_pkg::*;
(
    input  logic       i2c_clk,
    input  logic       rst_n,
    i2c_timing_if.gen  tim
);

    localparam int DIV = `I2C_QUARTER_DIV;
    localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CW-1:0] cnt_q;
    bus_phase_e    phase_q;
    logic          tick_q;

    // Quarter counter and phase register
    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            phase_q <= Q_LOW_A;
            tick_q  <= 1'b0;
        end else if (!tim.run) begin
            // Parked at the start of a bit so the next run begins cleanly
            cnt_q   <= '0;
            phase_q <= Q_LOW_A;
            tick_q  <= 1'b0;
        end else if (cnt_q == CW'(DIV - 1)) begin
            cnt_q   <= '0;
            phase_q <= bus_phase_e'(phase_q + 2'd1);
            tick_q  <= 1'b1;
        end else begin
            cnt_q   <= cnt_q + 1'b1;
            tick_q  <= 1'b0;
        end
    end

    assign tim.tick  = tick_q;
    assign tim.phase = phase_q;

    // SCL low in both outer quarters, high around the sample point
    assign tim.scl_low = tim.run && ((phase_q == Q_LOW_A) || (phase_q == Q_LOW_B));

endmodule

/* src/i2c_controller.sv */
`include "i2c_consts.svh"

module i2c_controller
    import i2c_bus_pkg::*;
    import i2c_cmd_pkg::*;
(
    input  logic        i2c_clk,
    input  logic        rst_n,
    input  logic        cmd_valid_i,
    input  i2c_cmd_t    cmd_i,
    output logic        cmd_ready_o,
    input  logic        sda_i,
    output logic        sda_oe_o,
    output logic        scl_oe_o,
    output logic        push_valid_o,
    output logic [7:0]  push_data_o,
    input  logic        push_ready_i,
    output logic        sts_valid_o,
    output logic        sts_nack_o,
    i2c_timing_if.ctrl  tim
);

    localparam logic [`I2C_LEN_W-1:0] MAX_LEN = `I2C_LEN_W'(`I2C_MAX_READ_LEN);

    ctrl_state_e           state_q;
    i2c_cmd_t              cmd_q;
    logic [7:0]            shift_q;
    logic [7:0]            rx_q;
    logic [7:0]            addr_byte;
    logic [2:0]            bit_cnt_q;
    logic [`I2C_LEN_W-1:0] rem_q;
    logic                  run_q;
    logic                  sda_oe_q;
    logic                  ack_q;
    logic                  nack_q;
    logic                  push_q;
    logic                  bit_start;
    logic                  sample;
    logic                  last_byte;

    // Bit boundary and sample point
    assign bit_start = tim.tick && (tim.phase == Q_LOW_A);
    assign sample    = tim.tick && (tim.phase == Q_HIGH);

    assign addr_byte = {cmd_q.addr, cmd_q.op == OP_READ};
    assign last_byte = (rem_q <= `I2C_LEN_W'(1));

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            run_q     <= 1'b0;
            sda_oe_q  <= 1'b0;
            bit_cnt_q <= '0;
            rem_q     <= '0;
            ack_q     <= 1'b0;
            nack_q    <= 1'b0;
            push_q    <= 1'b0;
        end else begin
            push_q <= 1'b0;
            case (state_q)
                IDLE, HOLD: begin
                    if (cmd_valid_i) begin
                        state_q  <= START;
                        run_q    <= 1'b1;
                        sda_oe_q <= 1'b0;
                        nack_q   <= 1'b0;
                        rem_q    <= (cmd_i.len > MAX_LEN) ? MAX_LEN : cmd_i.len;
                    end
                end
                START: begin
                    // SDA falls while SCL is high
                    if (sample) begin
                        sda_oe_q <= 1'b1;
                    end else if (bit_start) begin
                        state_q   <= ADDR;
                        sda_oe_q  <= ~addr_byte[7];
                        bit_cnt_q <= '0;
                    end
                end
                ADDR, WR_DATA: begin
                    if (bit_start) begin
                        if (bit_cnt_q == 3'd7) begin
                            state_q  <= (state_q == ADDR) ? ADDR_ACK : WR_ACK;
                            sda_oe_q <= 1'b0;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            sda_oe_q  <= ~shift_q[6];
                        end
                    end
                end
                ADDR_ACK: begin
                    if (sample) begin
                        ack_q <= ~sda_i;
                    end else if (bit_start) begin
                        bit_cnt_q <= '0;
                        if (!ack_q) begin
                            state_q  <= STOP;
                            nack_q   <= 1'b1;
                            sda_oe_q <= 1'b1;
                        end else if (cmd_q.op == OP_WRITE) begin
                            state_q  <= WR_DATA;
                            sda_oe_q <= ~cmd_q.data[7];
                        end else begin
                            state_q  <= push_ready_i ? RD_DATA : RD_WAIT;
                            run_q    <= push_ready_i;
                            sda_oe_q <= 1'b0;
                        end
                    end
                end
                WR_ACK: begin
                    // The data ACK is not checked
                    if (bit_start) begin
                        bit_cnt_q <= '0;
                        if (cmd_q.rstart) begin
                            state_q  <= HOLD;
                            run_q    <= 1'b0;
                            sda_oe_q <= 1'b0;
                        end else begin
                            state_q  <= STOP;
                            sda_oe_q <= 1'b1;
                        end
                    end
                end
                RD_WAIT: begin
                    // SCL stays low until the FIFO has room
                    if (push_ready_i) begin
                        state_q   <= RD_DATA;
                        run_q     <= 1'b1;
                        bit_cnt_q <= '0;
                    end
                end
                RD_DATA: begin
                    if (bit_start) begin
                        if (bit_cnt_q == 3'd7) begin
                            state_q  <= RD_ACK;
                            push_q   <= 1'b1;
                            // ACK all but the last byte
                            sda_oe_q <= ~last_byte;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                RD_ACK: begin
                    if (bit_start) begin
                        bit_cnt_q <= '0;
                        if (!last_byte) begin
                            rem_q    <= rem_q - 1'b1;
                            state_q  <= push_ready_i ? RD_DATA : RD_WAIT;
                            run_q    <= push_ready_i;
                            sda_oe_q <= 1'b0;
                        end else if (cmd_q.rstart) begin
                            state_q  <= HOLD;
                            run_q    <= 1'b0;
                            sda_oe_q <= 1'b0;
                        end else begin
                            state_q  <= STOP;
                            sda_oe_q <= 1'b1;
                        end
                    end
                end
                STOP: begin
                    // bit_cnt_q marks that SCL has gone high in this bit
                    if (sample) begin
                        sda_oe_q  <= 1'b0;
                        bit_cnt_q <= 3'd1;
                    end else if (bit_start) begin
                        state_q <= IDLE;
                        run_q   <= 1'b0;
                    end
                end
                default: begin
                    state_q  <= IDLE;
                    run_q    <= 1'b0;
                    sda_oe_q <= 1'b0;
                end
            endcase
        end
    end

    // Command, transmit shifter and receive shifter
    always_ff @(posedge i2c_clk) begin
        if (cmd_ready_o && cmd_valid_i) begin
            cmd_q <= cmd_i;
        end
        if (bit_start && (state_q == START)) begin
            shift_q <= addr_byte;
        end else if (bit_start && (state_q == ADDR_ACK)) begin
            shift_q <= cmd_q.data;
        end else if (bit_start && ((state_q == ADDR) || (state_q == WR_DATA))) begin
            shift_q <= shift_q << 1;
        end
        if (sample && (state_q == RD_DATA)) begin
            rx_q <= {rx_q[6:0], sda_i};
        end
    end

    always_comb begin
        case (state_q)
            RD_WAIT, HOLD: scl_oe_o = 1'b1;
            // Keep SCL high once STOP has released it
            STOP:          scl_oe_o = tim.scl_low && (bit_cnt_q == '0);
            default:       scl_oe_o = tim.scl_low;
        endcase
    end

    assign tim.run      = run_q;
    assign cmd_ready_o  = (state_q == IDLE) || (state_q == HOLD);
    assign sda_oe_o     = sda_oe_q;
    assign push_valid_o = push_q;
    assign push_data_o  = rx_q;

    // Last cycle before IDLE or HOLD
    assign sts_valid_o = bit_start && ((state_q == STOP) ||
                         (cmd_q.rstart && ((state_q == WR_ACK) ||
                                           ((state_q == RD_ACK) && last_byte))));
    assign sts_nack_o  = nack_q;

endmodule

/* src/i2c_rx_fifo.sv */
`include "i2c_consts.svh"

module i2c_rx_fifo (
    input  logic       i2c_clk,
    input  logic       rst_n,
    input  logic       push_valid_i,
    input  logic [7:0] push_data_i,
    output logic       push_ready_o,
    output logic       rx_valid_o,
    output logic [7:0] rx_data_o,
    input  logic       rx_ready_i
);

    localparam int DEPTH = `I2C_FIFO_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    logic [7:0]    mem_q [DEPTH];
    logic [PW-1:0] wptr_q;
    logic [PW-1:0] rptr_q;
    logic [CW-1:0] count_q;
    logic          do_push;
    logic          out_load;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_ready_o = (count_q != CW'(DEPTH));
    assign do_push      = push_valid_i && push_ready_o;
    // Refill the output register when it is empty or being taken
    assign out_load     = (count_q != '0) && (!rx_valid_o || rx_ready_i);

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr_q     <= '0;
            rptr_q     <= '0;
            count_q    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            if (do_push) begin
                wptr_q <= next_ptr(wptr_q);
            end
            if (out_load) begin
                rptr_q <= next_ptr(rptr_q);
            end
            if (do_push && !out_load) begin
                count_q <= count_q + 1'b1;
            end else if (!do_push && out_load) begin
                count_q <= count_q - 1'b1;
            end
            if (out_load) begin
                rx_valid_o <= 1'b1;
            end else if (rx_ready_i) begin
                rx_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge i2c_clk) begin
        if (do_push) begin
            mem_q[wptr_q] <= push_data_i;
        end
        if (out_load) begin
            rx_data_o <= mem_q[rptr_q];
        end
    end

endmodule

/* src/i2c_master_top.sv */
`include "i2c_consts.svh"

module i2c_master_top
    import i2c_cmd_pkg::*;
(
    input  logic                  i2c_clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid_i,
    input  logic                  cmd_op_i,
    input  logic [6:0]            cmd_addr_i,
    input  logic [7:0]            cmd_data_i,
    input  logic [`I2C_LEN_W-1:0] cmd_len_i,
    input  logic                  cmd_rstart_i,
    output logic                  cmd_ready_o,
    output logic                  rx_valid_o,
    output logic [7:0]            rx_data_o,
    input  logic                  rx_ready_i,
    output logic                  sts_valid_o,
    output logic                  sts_nack_o,
    input  logic                  sda_i,
    // Pad readback only, the slave cannot stretch the clock
    input  logic                  scl_i,
    output logic                  sda_oe_o,
    output logic                  scl_oe_o
);

    i2c_cmd_t   cmd;
    logic       push_valid;
    logic       push_ready;
    logic [7:0] push_data;

    i2c_timing_if tim_if ();

    assign cmd = '{
        op:     cmd_op_e'(cmd_op_i),
        addr:   cmd_addr_i,
        data:   cmd_data_i,
        len:    cmd_len_i,
        rstart: cmd_rstart_i
    };

    i2c_scl_gen u_scl_gen (
        .i2c_clk (i2c_clk),
        .rst_n   (rst_n),
        .tim     (tim_if.gen)
    );

    i2c_controller u_controller (
        .i2c_clk      (i2c_clk),
        .rst_n        (rst_n),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd),
        .cmd_ready_o  (cmd_ready_o),
        .sda_i        (sda_i),
        .sda_oe_o     (sda_oe_o),
        .scl_oe_o     (scl_oe_o),
        .push_valid_o (push_valid),
        .push_data_o  (push_data),
        .push_ready_i (push_ready),
        .sts_valid_o  (sts_valid_o),
        .sts_nack_o   (sts_nack_o),
        .tim          (tim_if.ctrl)
    );

    i2c_rx_fifo u_rx_fifo (
        .i2c_clk      (i2c_clk),
        .rst_n        (rst_n),
        .push_valid_i (push_valid),
        .push_data_i  (push_data),
        .push_ready_o (push_ready),
        .rx_valid_o   (rx_valid_o),
        .rx_data_o    (rx_data_o),
        .rx_ready_i   (rx_ready_i)
    );

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 3
) (
    output logic i2c_clk,
    output logic rst_n
);

    initial begin
        i2c_clk = 1'b0;
        forever begin
            #(PERIOD / 2) i2c_clk = ~i2c_clk;
        end
    end

    // Reset released on a falling edge, clear of the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge i2c_clk);
        @(negedge i2c_clk);
        rst_n = 1'b1;
    end

endmodule

/* dv/i2c_slave_model.sv */
module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h2A
) (
    input  logic scl_i,
    input  logic sda_i,
    output logic sda_oe_o
);

    typedef enum int {S_IDLE, S_ADDR, S_ACK, S_WR, S_RD, S_MACK} slv_state_e;

    logic [7:0] mem [16];
    logic [3:0] ptr;
    logic [7:0] shift;
    logic [7:0] tx;
    logic       rw;
    logic       ack_due;
    logic       in_frame;
    logic       mack;
    int         cnt;
    int         start_cnt;
    int         rstart_cnt;
    int         stop_cnt;
    slv_state_e st;

    initial begin
        for (int i = 0; i < 16; i++) begin
            mem[i] = 8'((i * 37 + 5) % 256);
        end
        ptr        = '0;
        sda_oe_o   = 1'b0;
        st         = S_IDLE;
        ack_due    = 1'b0;
        in_frame   = 1'b0;
        cnt        = 0;
        start_cnt  = 0;
        rstart_cnt = 0;
        stop_cnt   = 0;
    end

    // START and repeated START
    always @(negedge sda_i) begin
        if (scl_i === 1'b1) begin
            if (in_frame) begin
                rstart_cnt++;
            end else begin
                start_cnt++;
            end
            in_frame = 1'b1;
            st       = S_ADDR;
            cnt      = 0;
            ack_due  = 1'b0;
            sda_oe_o = 1'b0;
        end
    end

    always @(posedge sda_i) begin
        if (scl_i === 1'b1) begin
            stop_cnt++;
            in_frame = 1'b0;
            st       = S_IDLE;
            sda_oe_o = 1'b0;
        end
    end

    // Sample on the rising SCL edge
    always @(posedge scl_i) begin
        case (st)
            S_ADDR, S_WR: begin
                shift = {shift[6:0], sda_i};
                cnt++;
                if (cnt == 8) begin
                    if (st == S_ADDR) begin
                        rw      = shift[0];
                        ack_due = (shift[7:1] == ADDR);
                        if (!ack_due) begin
                            st = S_IDLE;
                        end
                    end else begin
                        ptr     = shift[3:0];
                        ack_due = 1'b1;
                    end
                end
            end
            S_RD:    cnt++;
            S_MACK:  mack = !sda_i;
            default: ;
        endcase
    end

    // Drive on the falling SCL edge
    always @(negedge scl_i) begin
        if (ack_due) begin
            ack_due  = 1'b0;
            sda_oe_o = 1'b1;
            st       = S_ACK;
        end else if (st == S_ACK || (st == S_MACK && mack)) begin
            if (st == S_ACK && !rw) begin
                sda_oe_o = 1'b0;
                st       = S_WR;
                cnt      = 0;
            end else begin
                tx       = mem[ptr];
                ptr      = ptr + 4'd1;
                sda_oe_o = ~tx[7];
                st       = S_RD;
                cnt      = 0;
            end
        end else if (st == S_MACK) begin
            // Master NACK ends the read
            sda_oe_o = 1'b0;
            st       = S_IDLE;
        end else if (st == S_RD) begin
            if (cnt == 8) begin
                sda_oe_o = 1'b0;
                st       = S_MACK;
            end else begin
                sda_oe_o = ~tx[7 - cnt];
            end
        end
    end

endmodule

/* dv/tb_i2c_master.sv */
`include "i2c_consts.svh"

module tb_i2c_master
    import i2c_cmd_pkg::*;
();

    localparam int TIMEOUT = 4000;
    localparam logic [6:0] SLV_ADDR = 7'h2A;

    logic                  i2c_clk;
    logic                  rst_n;
    logic                  cmd_valid_i;
    logic                  cmd_op_i;
    logic [6:0]            cmd_addr_i;
    logic [7:0]            cmd_data_i;
    logic [`I2C_LEN_W-1:0] cmd_len_i;
    logic                  cmd_rstart_i;
    logic                  cmd_ready_o;
    logic                  rx_valid_o;
    logic [7:0]            rx_data_o;
    logic                  rx_ready_i;
    logic                  sts_valid_o;
    logic                  sts_nack_o;
    logic                  sda_oe_o;
    logic                  scl_oe_o;
    logic                  slv_sda_oe;
    wire                   sda_bus;
    wire                   scl_bus;

    int         errors;
    int         checks;
    int         rx_count;
    int         sts_cnt;
    logic       last_nack;
    integer     seed;
    logic [7:0] exp_q [$];

    // Wired-AND bus with pull-ups
    assign sda_bus = ~(sda_oe_o | slv_sda_oe);
    assign scl_bus = ~scl_oe_o;

    tb_clk_gen #(.PERIOD(40), .RST_CYCLES(3)) u_clk (
        .i2c_clk (i2c_clk),
        .rst_n   (rst_n)
    );

    i2c_master_top DUT (
        .i2c_clk      (i2c_clk),
        .rst_n        (rst_n),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_op_i     (cmd_op_i),
        .cmd_addr_i   (cmd_addr_i),
        .cmd_data_i   (cmd_data_i),
        .cmd_len_i    (cmd_len_i),
        .cmd_rstart_i (cmd_rstart_i),
        .cmd_ready_o  (cmd_ready_o),
        .rx_valid_o   (rx_valid_o),
        .rx_data_o    (rx_data_o),
        .rx_ready_i   (rx_ready_i),
        .sts_valid_o  (sts_valid_o),
        .sts_nack_o   (sts_nack_o),
        .sda_i        (sda_bus),
        .scl_i        (scl_bus),
        .sda_oe_o     (sda_oe_o),
        .scl_oe_o     (scl_oe_o)
    );

    i2c_slave_model #(.ADDR(SLV_ADDR)) u_slave (
        .scl_i    (scl_bus),
        .sda_i    (sda_bus),
        .sda_oe_o (slv_sda_oe)
    );

    // Expected slave byte at a pointer plus an offset
    function automatic logic [7:0] exp_byte(input int ptr, input int off);
        int idx;
        idx = (ptr + off) % 16;
        return 8'((idx * 37 + 5) % 256);
    endfunction

    task automatic check_val(input string msg, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic abort_timeout(input string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic send_cmd(input logic op, input logic [6:0] addr, input logic [7:0] data,
                            input int len, input logic rstart);
        int n;
        n = 0;
        @(posedge i2c_clk);
        cmd_valid_i  <= 1'b1;
        cmd_op_i     <= op;
        cmd_addr_i   <= addr;
        cmd_data_i   <= data;
        cmd_len_i    <= `I2C_LEN_W'(len);
        cmd_rstart_i <= rstart;
        @(negedge i2c_clk);
        while (!cmd_ready_o) begin
            if (n >= TIMEOUT) begin
                abort_timeout("command ready");
            end
            n++;
            @(negedge i2c_clk);
        end
        @(posedge i2c_clk);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic wait_status(input int target);
        int n;
        n = 0;
        while (sts_cnt < target) begin
            if (n >= TIMEOUT) begin
                abort_timeout("command status");
            end
            n++;
            @(negedge i2c_clk);
        end
    endtask

    task automatic wait_rx(input int target);
        int n;
        n = 0;
        while (rx_count < target) begin
            if (n >= TIMEOUT) begin
                abort_timeout("received bytes");
            end
            n++;
            @(negedge i2c_clk);
        end
    endtask

    task automatic run_cmd(input logic op, input logic [6:0] addr, input logic [7:0] data,
                           input int len, input logic rstart, input logic exp_nack);
        int target;
        target = sts_cnt + 1;
        send_cmd(op, addr, data, len, rstart);
        wait_status(target);
        check_val("status nack", last_nack, exp_nack);
    endtask

    always @(negedge i2c_clk) begin
        if (rst_n && sts_valid_o) begin
            sts_cnt++;
            last_nack = sts_nack_o;
        end
    end

    // Compare every popped byte against the expected queue
    always @(negedge i2c_clk) begin
        if (rst_n && rx_valid_o && rx_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected rx byte %0h at %0t", rx_data_o, $time);
            end else begin
                check_val("rx byte", rx_data_o, exp_q.pop_front());
            end
            rx_count++;
        end
    end

    initial begin
        int p;
        int l;
        int n;
        int base;
        int tgt;
        int stops;
        int starts;
        int rstarts;
        errors       = 0;
        checks       = 0;
        rx_count     = 0;
        sts_cnt      = 0;
        last_nack    = 1'b0;
        seed         = 32'hb46f83ad;
        cmd_valid_i  = 1'b0;
        cmd_op_i     = 1'b0;
        cmd_addr_i   = '0;
        cmd_data_i   = '0;
        cmd_len_i    = '0;
        cmd_rstart_i = 1'b0;
        rx_ready_i   = 1'b1;
        n            = 0;
        @(negedge i2c_clk);
        while (!rst_n) begin
            if (n >= TIMEOUT) begin
                abort_timeout("reset release");
            end
            n++;
            @(negedge i2c_clk);
        end

        // Idle outputs after reset
        check_val("sda_oe after reset", sda_oe_o, 0);
        check_val("scl_oe after reset", scl_oe_o, 0);
        check_val("cmd_ready after reset", cmd_ready_o, 1);
        check_val("rx_valid after reset", rx_valid_o, 0);
        check_val("sts_valid after reset", sts_valid_o, 0);

        run_cmd(OP_WRITE, SLV_ADDR, 8'h5B, 0, 1'b0, 1'b0);
        check_val("slave pointer after write", u_slave.ptr, 4'hB);

        // Wrong address
        stops = u_slave.stop_cnt;
        base  = rx_count;
        run_cmd(OP_WRITE, 7'h15, 8'h03, 0, 1'b0, 1'b1);
        run_cmd(OP_READ, 7'h15, 8'h00, 3, 1'b0, 1'b1);
        repeat (50) @(negedge i2c_clk);
        check_val("rx count after nack", rx_count, base);
        check_val("stop count after nack", u_slave.stop_cnt, stops + 2);

        // Random pointer and length
        repeat (6) begin
            p = $random(seed) & 15;
            l = ($random(seed) & 3) + 1;
            run_cmd(OP_WRITE, SLV_ADDR, 8'(p), 0, 1'b0, 1'b0);
            for (int i = 0; i < l; i++) begin
                exp_q.push_back(exp_byte(p, i));
            end
            tgt = rx_count + l;
            run_cmd(OP_READ, SLV_ADDR, 8'h00, l, 1'b0, 1'b0);
            wait_rx(tgt);
            repeat (30) @(negedge i2c_clk);
            check_val("rx count after read", rx_count, tgt);
            check_val("slave pointer after read", u_slave.ptr, (p + l) % 16);
        end

        // Write then read across a repeated START
        p       = $random(seed) & 15;
        stops   = u_slave.stop_cnt;
        starts  = u_slave.start_cnt;
        rstarts = u_slave.rstart_cnt;
        run_cmd(OP_WRITE, SLV_ADDR, 8'(p), 0, 1'b1, 1'b0);
        check_val("stop count in hold", u_slave.stop_cnt, stops);
        exp_q.push_back(exp_byte(p, 0));
        exp_q.push_back(exp_byte(p, 1));
        tgt = rx_count + 2;
        run_cmd(OP_READ, SLV_ADDR, 8'h00, 2, 1'b0, 1'b0);
        wait_rx(tgt);
        check_val("start count across repeated start", u_slave.start_cnt, starts + 1);
        check_val("repeated start count", u_slave.rstart_cnt, rstarts + 1);
        check_val("stop count after read", u_slave.stop_cnt, stops + 1);

        // Back-pressure over two full reads
        p = $random(seed) & 15;
        @(posedge i2c_clk);
        rx_ready_i <= 1'b0;
        run_cmd(OP_WRITE, SLV_ADDR, 8'(p), 0, 1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            exp_q.push_back(exp_byte(p, i));
        end
        base = rx_count;
        tgt  = sts_cnt + 2;
        send_cmd(OP_READ, SLV_ADDR, 8'h00, 4, 1'b0);
        send_cmd(OP_READ, SLV_ADDR, 8'h00, 4, 1'b0);
        repeat (400) @(negedge i2c_clk);
        // Second read parked with SCL low and the output register full
        check_val("status count while stalled", sts_cnt, tgt - 1);
        check_val("scl held low while stalled", scl_oe_o, 1);
        check_val("rx_valid while stalled", rx_valid_o, 1);
        @(posedge i2c_clk);
        rx_ready_i <= 1'b1;
        wait_status(tgt);
        check_val("status nack after stall", last_nack, 1'b0);
        wait_rx(base + 8);

        repeat (20) @(negedge i2c_clk);
        check_val("bytes left unreceived", exp_q.size(), 0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
src/i2c_bus_pkg.sv
src/i2c_cmd_pkg.sv
src/i2c_timing_if.sv
src/i2c_scl_gen.sv
src/i2c_controller.sv
src/i2c_rx_fifo.sv
src/i2c_master_top.sv
dv/tb_clk_gen.sv
dv/i2c_slave_model.sv
dv/tb_i2c_master.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_i2c_master \
    -f sources.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1
